//--- verilog/sha1_pkg.sv
// SHA-1 hub shared types for the byte-stream ports and the compression engine

package sha1_pkg;

	// ------------------------------------------------------------------------
	// Basic widths
	// ------------------------------------------------------------------------

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;

	// Chaining value / digest, h0 in the top word
	typedef logic [159:0] digest_t;

	// ------------------------------------------------------------------------
	// Host byte streams
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic sof;
		logic eof;
		logic src_rdy;
		byte_t data;
	} stream_in_t;

	typedef struct packed {
		logic sof;
		logic eof;
		logic src_rdy;
		byte_t data;
	} stream_out_t;

	// ------------------------------------------------------------------------
	// Port to engine traffic
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic load;
		word_t word;
		logic start;
		logic use_prev_cv;
	} core_req_t;

	typedef struct packed {
		logic busy;
		logic out_valid;
		digest_t cv_next;
	} core_rsp_t;

endpackage

//--- verilog/sha1_exec.sv
// SHA-1 compression engine, 16-word load, 80 rounds, chaining value update

module sha1_exec (
	input logic clk,
	input logic rst,
	input sha1_pkg::core_req_t req,
	output sha1_pkg::core_rsp_t rsp
);

	// Standard initial hash value h0..h4
	localparam sha1_pkg::digest_t iv = 160'h67452301_efcdab89_98badcfe_10325476_c3d2e1f0;

	// ------------------------------------------------------------------------
	// State
	// ------------------------------------------------------------------------

	// Message schedule window, w[0] is W(t) of the current round
	sha1_pkg::word_t w [16];

	sha1_pkg::word_t a;
	sha1_pkg::word_t b;
	sha1_pkg::word_t c;
	sha1_pkg::word_t d;
	sha1_pkg::word_t e;

	// Base of the running block, then the result once the block ends
	sha1_pkg::digest_t cv;

	logic busy;
	logic fin;
	logic out_valid;
	logic [6:0] rnd;

	// Round datapath
	sha1_pkg::word_t f;
	sha1_pkg::word_t k;
	sha1_pkg::word_t t;
	sha1_pkg::word_t w_mix;
	sha1_pkg::word_t w_new;
	sha1_pkg::word_t w_in;
	sha1_pkg::digest_t base;
	logic go;
	logic shift_en;

	assign go = req.start & ~busy;
	assign base = req.use_prev_cv ? cv : iv;

	// ------------------------------------------------------------------------
	// Round function
	// ------------------------------------------------------------------------

	always_comb
	begin
		if (rnd < 7'd20)
		begin
			f = (b & c) | (~b & d);
			k = 32'h5a827999;
		end
		else if (rnd < 7'd40)
		begin
			f = b ^ c ^ d;
			k = 32'h6ed9eba1;
		end
		else if (rnd < 7'd60)
		begin
			f = (b & c) | (b & d) | (c & d);
			k = 32'h8f1bbcdc;
		end
		else
		begin
			f = b ^ c ^ d;
			k = 32'hca62c1d6;
		end
	end

	assign t = {a[26:0], a[31:27]} + f + e + k + w[0];

	// W(t+16) from the window
	assign w_mix = w[13] ^ w[8] ^ w[2] ^ w[0];
	assign w_new = {w_mix[30:0], w_mix[31]};

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			fin <= 1'b0;
			out_valid <= 1'b0;
			rnd <= '0;
		end
		else
		begin
			// One idle cycle for the final add, then the result strobe
			fin <= busy & (rnd == 7'd79);
			out_valid <= fin;
			if (go)
			begin
				busy <= 1'b1;
				rnd <= '0;
			end
			else if (busy)
			begin
				if (rnd == 7'd79)
					busy <= 1'b0;
				rnd <= rnd + 7'd1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Message window
	// ------------------------------------------------------------------------

	// Host words shift in while idle, expanded words while running
	assign shift_en = busy | req.load;
	assign w_in = busy ? w_new : req.word;

	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= w_in;
		end
	end

	// ------------------------------------------------------------------------
	// Working registers and chaining value
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (go)
		begin
			{a, b, c, d, e} <= base;
			cv <= base;
		end
		else if (busy)
		begin
			a <= t;
			b <= a;
			c <= {b[1:0], b[31:2]};
			d <= c;
			e <= d;
		end
		else if (fin)
		begin
			// Per-word add, carries dropped at 32 bits
			cv <= {cv[159:128] + a, cv[127:96] + b, cv[95:64] + c,
				cv[63:32] + d, cv[31:0] + e};
		end
	end

	assign rsp = '{busy: busy, out_valid: out_valid, cv_next: cv};

endmodule

//--- verilog/sha1_port.sv
// SHA-1 byte-stream channel, packs message words and serializes the digest

module sha1_port (
	input logic clk,
	input logic rst,
	input sha1_pkg::stream_in_t in,
	output logic in_dst_rdy,
	output sha1_pkg::stream_out_t out,
	input logic out_dst_rdy,
	output logic req,
	input logic grant,
	output sha1_pkg::core_req_t core,
	input sha1_pkg::core_rsp_t rsp
);

	typedef enum logic [3:0] {
		wr_idle,
		wr_grant,
		wr_byte0,
		wr_byte1,
		wr_byte2,
		wr_word,
		wr_start,
		wr_busy,
		wr_result
	} wr_state_t;

	typedef enum logic [1:0] {
		rd_wait,
		rd_first,
		rd_reading
	} rd_state_t;

	wr_state_t wr_state;
	wr_state_t wr_next;
	rd_state_t rd_state;
	rd_state_t rd_next;

	logic [3:0] word_cnt;
	logic [23:0] in_shift;
	logic last_blk;
	logic use_prev_cv;
	logic byte_phase;
	logic in_xfer;
	logic out_xfer;
	logic final_done;

	sha1_pkg::digest_t out_shift;
	logic [4:0] byte_cnt;

	// ------------------------------------------------------------------------
	// Write side
	// ------------------------------------------------------------------------

	assign byte_phase = (wr_state == wr_byte0) || (wr_state == wr_byte1) ||
		(wr_state == wr_byte2) || (wr_state == wr_word);

	// Bytes move only while this port owns an idle engine
	assign in_dst_rdy = byte_phase & grant & ~rsp.busy;
	assign in_xfer = in_dst_rdy & in.src_rdy;
	assign final_done = (wr_state == wr_result) & rsp.out_valid;

	always_comb
	begin
		wr_next = wr_state;
		case (wr_state)
			wr_idle:
				// Hold off a new message until the last digest is gone
				if (in.src_rdy && in.sof && rd_state == rd_wait)
					wr_next = wr_grant;
			wr_grant:
				if (grant && !rsp.busy)
					wr_next = wr_byte0;
			wr_byte0:
				if (in_xfer)
					wr_next = wr_byte1;
			wr_byte1:
				if (in_xfer)
					wr_next = wr_byte2;
			wr_byte2:
				if (in_xfer)
					wr_next = wr_word;
			wr_word:
				if (in_xfer)
					wr_next = (word_cnt == 4'd15) ? wr_start : wr_byte0;
			wr_start:
				wr_next = last_blk ? wr_result : wr_busy;
			wr_busy:
				if (!rsp.busy)
					wr_next = wr_byte0;
			wr_result:
				if (rsp.out_valid)
					wr_next = wr_idle;
			default:
				wr_next = wr_idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_state <= wr_idle;
			word_cnt <= '0;
			last_blk <= 1'b0;
			use_prev_cv <= 1'b0;
		end
		else
		begin
			wr_state <= wr_next;
			// Wraps to zero after the 16th word
			if (wr_state == wr_word && in_xfer)
				word_cnt <= word_cnt + 4'd1;
			if (wr_state == wr_word && in_xfer && word_cnt == 4'd15)
				last_blk <= in.eof;
			if (wr_state == wr_idle)
				use_prev_cv <= 1'b0;
			else if (wr_state == wr_busy)
				use_prev_cv <= 1'b1;
		end
	end

	// First three bytes of a word, oldest in the top byte
	always_ff @(posedge clk)
	begin
		if (in_xfer && wr_state != wr_word)
			in_shift <= {in_shift[15:0], in.data};
	end

	assign req = (wr_state != wr_idle);

	assign core = '{
		load: (wr_state == wr_word) & in_xfer,
		word: {in_shift, in.data},
		start: (wr_state == wr_start),
		use_prev_cv: use_prev_cv
	};

	// ------------------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------------------

	assign out_xfer = out.src_rdy & out_dst_rdy;

	always_comb
	begin
		rd_next = rd_state;
		case (rd_state)
			rd_wait:
				if (final_done)
					rd_next = rd_first;
			rd_first:
				if (out_xfer)
					rd_next = rd_reading;
			rd_reading:
				if (out_xfer && byte_cnt == 5'd1)
					rd_next = rd_wait;
			default:
				rd_next = rd_wait;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd_state <= rd_wait;
			byte_cnt <= '0;
		end
		else
		begin
			rd_state <= rd_next;
			if (final_done)
				byte_cnt <= 5'd20;
			else if (out_xfer)
				byte_cnt <= byte_cnt - 5'd1;
		end
	end

	// Digest goes out h0 first, top byte first
	always_ff @(posedge clk)
	begin
		if (final_done)
			out_shift <= rsp.cv_next;
		else if (out_xfer)
			out_shift <= {out_shift[151:0], 8'h00};
	end

	assign out = '{
		sof: (rd_state == rd_first),
		eof: (rd_state == rd_reading) && (byte_cnt == 5'd1),
		src_rdy: (rd_state != rd_wait),
		data: out_shift[159:152]
	};

endmodule

//--- verilog/sha1_core_arbiter.sv
// Round-robin engine ownership for the SHA-1 ports, request mux and response steering

module sha1_core_arbiter #(
	parameter int n_ports = 2
) (
	input logic clk,
	input logic rst,
	input logic [n_ports-1:0] req,
	input sha1_pkg::core_req_t port_req [n_ports],
	output logic [n_ports-1:0] grant,
	output sha1_pkg::core_req_t core_req,
	input sha1_pkg::core_rsp_t core_rsp,
	output sha1_pkg::core_rsp_t port_rsp [n_ports]
);

	localparam int idx_w = (n_ports > 1) ? $clog2(n_ports) : 1;

	typedef logic [idx_w-1:0] idx_t;

	// Owner index, kept as the round-robin pointer after release
	idx_t owner;
	logic owner_vld;
	idx_t nxt_owner;
	logic nxt_found;

	// Search starts one past the last owner and ends on it
	always_comb
	begin
		int cand;
		nxt_found = 1'b0;
		nxt_owner = owner;
		for (int i = 1; i <= n_ports; i++)
		begin
			cand = (int'(owner) + i) % n_ports;
			if (!nxt_found && req[cand])
			begin
				nxt_found = 1'b1;
				nxt_owner = idx_t'(cand);
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			owner_vld <= 1'b0;
			owner <= idx_t'(n_ports - 1);
		end
		else if (!owner_vld || !req[owner])
		begin
			owner_vld <= nxt_found;
			owner <= nxt_owner;
		end
	end

	// Non-owners see a busy engine and no results
	always_comb
	begin
		core_req = '0;
		for (int i = 0; i < n_ports; i++)
		begin
			grant[i] = owner_vld && (owner == idx_t'(i));
			port_rsp[i].cv_next = core_rsp.cv_next;
			port_rsp[i].busy = grant[i] ? core_rsp.busy : 1'b1;
			port_rsp[i].out_valid = grant[i] & core_rsp.out_valid;
			if (grant[i])
				core_req = port_req[i];
		end
	end

endmodule

//--- verilog/sha1_hub.sv
// SHA-1 hub top, byte-stream ports sharing one compression engine

module sha1_hub #(
	parameter int n_ports = 2
) (
	input logic clk,
	input logic rst,
	input sha1_pkg::stream_in_t in [n_ports],
	output logic [n_ports-1:0] in_dst_rdy,
	output sha1_pkg::stream_out_t out [n_ports],
	input logic [n_ports-1:0] out_dst_rdy
);

	logic [n_ports-1:0] req;
	logic [n_ports-1:0] grant;
	sha1_pkg::core_req_t port_req [n_ports];
	sha1_pkg::core_rsp_t port_rsp [n_ports];
	sha1_pkg::core_req_t core_req;
	sha1_pkg::core_rsp_t core_rsp;

	// ------------------------------------------------------------------------
	// Channel ports
	// ------------------------------------------------------------------------

	for (genvar i = 0; i < n_ports; i++)
	begin : g_port
		sha1_port i_port (
			.clk(clk),
			.rst(rst),
			.in(in[i]),
			.in_dst_rdy(in_dst_rdy[i]),
			.out(out[i]),
			.out_dst_rdy(out_dst_rdy[i]),
			.req(req[i]),
			.grant(grant[i]),
			.core(port_req[i]),
			.rsp(port_rsp[i])
		);
	end

	// ------------------------------------------------------------------------
	// Shared engine
	// ------------------------------------------------------------------------

	sha1_core_arbiter #(
		.n_ports(n_ports)
	) i_arbiter (
		.clk(clk),
		.rst(rst),
		.req(req),
		.port_req(port_req),
		.grant(grant),
		.core_req(core_req),
		.core_rsp(core_rsp),
		.port_rsp(port_rsp)
	);

	sha1_exec i_exec (
		.clk(clk),
		.rst(rst),
		.req(core_req),
		.rsp(core_rsp)
	);

endmodule

//--- testbench/sha1_hub_sva.sv
// SHA-1 hub bound assertions on engine ownership, start timing and digest stream stability

module sha1_hub_assert #(
	parameter int n_grant = 1,
	parameter bit on_port = 1'b0
) (
	input logic clk,
	input logic rst,
	input logic [n_grant-1:0] grant,
	input logic start,
	input logic busy,
	input sha1_pkg::stream_out_t out,
	input logic out_dst_rdy
);
	timeunit 1ns;
	timeprecision 100ps;

	a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else $error("engine start while the engine is busy");

	if (!on_port)
	begin : g_arbiter
		// At most one owner of the engine
		a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
			else $error("grant is not one-hot or zero");
	end
	else
	begin : g_port
		// Stalled digest byte holds data and flags
		a_out_stable: assert property (@(posedge clk) disable iff (rst)
			out.src_rdy && !out_dst_rdy |=> out.src_rdy && $stable(out))
			else $error("stalled output byte changed");
	end

endmodule

bind sha1_core_arbiter sha1_hub_assert #(
	.n_grant(n_ports),
	.on_port(1'b0)
) i_arb_sva (
	.clk(clk),
	.rst(rst),
	.grant(grant),
	.start(core_req.start),
	.busy(core_rsp.busy),
	.out('0),
	.out_dst_rdy(1'b1)
);

bind sha1_port sha1_hub_assert #(
	.n_grant(1),
	.on_port(1'b1)
) i_port_sva (
	.clk(clk),
	.rst(rst),
	.grant(grant),
	.start(core.start),
	.busy(rsp.busy),
	.out(out),
	.out_dst_rdy(out_dst_rdy)
);

//--- testbench/sha1_hub_tb.sv
// SHA-1 hub testbench with random padded messages checked against a SHA-1 model

module sha1_hub_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_ports = 2;
	localparam int n_msgs = 18;
	localparam int max_blocks = 3;
	localparam int watchdog_cycles = n_msgs * (max_blocks * 200 + 100) + 100;

	logic clk;
	logic rst;
	sha1_pkg::stream_in_t in_s [n_ports];
	logic [n_ports-1:0] in_rdy;
	sha1_pkg::stream_out_t out_s [n_ports];
	logic [n_ports-1:0] out_rdy;

	int seed;
	int gap_seed [n_ports];
	int stall_seed [n_ports];
	int cyc;
	int errors;
	int checks;
	int tests;

	// Current padded message and its expected digest, per port
	sha1_pkg::byte_t msg [n_ports][max_blocks * 64];
	int n_bytes [n_ports];
	sha1_pkg::digest_t expect_dg [n_ports];
	int last_in_cyc [n_ports];

	sha1_hub #(
		.n_ports(n_ports)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.in(in_s),
		.in_dst_rdy(in_rdy),
		.out(out_s),
		.out_dst_rdy(out_rdy)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	function automatic int pick(inout int s, input int n);
		return $unsigned($random(s)) % n;
	endfunction

	function automatic sha1_pkg::word_t rotl(input sha1_pkg::word_t x, input int n);
		return (x << n) | (x >> (32 - n));
	endfunction

	function automatic sha1_pkg::digest_t sha1_ref(input int p);
		sha1_pkg::word_t h [5];
		sha1_pkg::word_t w [80];
		sha1_pkg::word_t a, b, c, d, e;
		sha1_pkg::word_t f, k, tmp;
		int base;
		h = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476, 32'hc3d2e1f0};
		for (int blk = 0; blk < n_bytes[p] / 64; blk++)
		begin
			base = blk * 64;
			for (int t = 0; t < 16; t++)
				w[t] = {msg[p][base + 4 * t], msg[p][base + 4 * t + 1],
					msg[p][base + 4 * t + 2], msg[p][base + 4 * t + 3]};
			for (int t = 16; t < 80; t++)
				w[t] = rotl(w[t - 3] ^ w[t - 8] ^ w[t - 14] ^ w[t - 16], 1);
			a = h[0];
			b = h[1];
			c = h[2];
			d = h[3];
			e = h[4];
			for (int t = 0; t < 80; t++)
			begin
				if (t < 20)
				begin
					f = (b & c) | (~b & d);
					k = 32'h5a827999;
				end
				else if (t < 40)
				begin
					f = b ^ c ^ d;
					k = 32'h6ed9eba1;
				end
				else if (t < 60)
				begin
					f = (b & c) | (b & d) | (c & d);
					k = 32'h8f1bbcdc;
				end
				else
				begin
					f = b ^ c ^ d;
					k = 32'hca62c1d6;
				end
				tmp = rotl(a, 5) + f + e + k + w[t];
				e = d;
				d = c;
				c = rotl(b, 30);
				b = a;
				a = tmp;
			end
			h[0] = h[0] + a;
			h[1] = h[1] + b;
			h[2] = h[2] + c;
			h[3] = h[3] + d;
			h[4] = h[4] + e;
		end
		return {h[0], h[1], h[2], h[3], h[4]};
	endfunction

	// ------------------------------------------------------------------------
	// Checks and reporting
	// ------------------------------------------------------------------------

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_framing(input int p, input string what);
		errors++;
		$display("port %0d framing fault at %0t: %s", p, $time, what);
	endtask

	task automatic end_test(input string name, input int e0);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == e0) ? "ok" : "FAILED");
	endtask

	// ------------------------------------------------------------------------
	// Stimulus and collection
	// ------------------------------------------------------------------------

	// Random payload, then 0x80, zeros and the 64-bit bit length
	task automatic build_msg(input int p, input int nb);
		int len;
		int lo;
		logic [31:0] r;
		logic [63:0] bitlen;
		lo = (nb == 1) ? 0 : nb * 64 - 72;
		len = lo + pick(seed, nb * 64 - 8 - lo);
		n_bytes[p] = nb * 64;
		for (int i = 0; i < nb * 64; i++)
		begin
			r = $random(seed);
			msg[p][i] = (i < len) ? r[7:0] : 8'h00;
		end
		msg[p][len] = 8'h80;
		bitlen = 64'(len) * 64'd8;
		for (int i = 0; i < 8; i++)
			msg[p][nb * 64 - 1 - i] = bitlen[8 * i +: 8];
		expect_dg[p] = sha1_ref(p);
	endtask

	task automatic send_msg(input int p, input bit gaps);
		for (int i = 0; i < n_bytes[p]; i++)
		begin
			if (gaps && pick(gap_seed[p], 4) == 0)
			begin
				@(negedge clk);
				in_s[p].src_rdy = 1'b0;
				repeat (pick(gap_seed[p], 3))
					@(negedge clk);
			end
			@(negedge clk);
			in_s[p].sof = (i == 0);
			in_s[p].eof = (i == n_bytes[p] - 1);
			in_s[p].data = msg[p][i];
			in_s[p].src_rdy = 1'b1;
			@(posedge clk);
			while (!in_rdy[p])
				@(posedge clk);
			if (i == n_bytes[p] - 1)
				last_in_cyc[p] = cyc;
		end
		@(negedge clk);
		in_s[p] = '0;
	endtask

	task automatic collect(input int p, input bit stalls);
		int k;
		bit seen;
		k = 0;
		seen = 1'b0;
		while (k < 20)
		begin
			@(negedge clk);
			out_rdy[p] = !stalls || pick(stall_seed[p], 3) != 0;
			@(posedge clk);
			// Rise of src_rdy counted from the last input edge
			if (out_s[p].src_rdy && !seen)
			begin
				seen = 1'b1;
				compare($sformatf("port %0d first output latency", p),
					cyc - last_in_cyc[p] - 1, 83);
			end
			if (out_s[p].src_rdy && out_rdy[p])
			begin
				compare($sformatf("out[%0d].data", p), out_s[p].data,
					expect_dg[p][159 - 8 * k -: 8]);
				if (out_s[p].sof != (k == 0) || out_s[p].eof != (k == 19))
					report_framing(p, $sformatf("sof or eof wrong on digest byte %0d", k));
				k++;
			end
		end
		@(negedge clk);
		out_rdy[p] = 1'b0;
		@(posedge clk);
		if (out_s[p].src_rdy)
			report_framing(p, "digest still offered after its 20th byte");
	endtask

	task automatic exchange(input int p, input bit noisy);
		fork
			send_msg(p, noisy);
			collect(p, noisy);
		join
	endtask

	task automatic run_both(input bit noisy);
		build_msg(0, 1 + pick(seed, max_blocks));
		build_msg(1, 1 + pick(seed, max_blocks));
		fork
			exchange(0, noisy);
			exchange(1, noisy);
		join
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial
	begin
		int e0;
		clk = 1'b0;
		rst = 1'b1;
		cyc = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		seed = 32'h34a5847b;
		out_rdy = '0;
		for (int p = 0; p < n_ports; p++)
		begin
			in_s[p] = '0;
			gap_seed[p] = $random(seed);
			stall_seed[p] = $random(seed);
			last_in_cyc[p] = 0;
		end
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		e0 = errors;
		repeat (8)
		begin
			@(posedge clk);
			compare("in_dst_rdy", in_rdy, 0);
			compare("out[0].src_rdy", out_s[0].src_rdy, 0);
			compare("out[1].src_rdy", out_s[1].src_rdy, 0);
		end
		end_test("idle after reset", e0);

		e0 = errors;
		build_msg(0, 1);
		exchange(0, 1'b0);
		end_test("single block on port 0", e0);

		e0 = errors;
		build_msg(0, 2);
		exchange(0, 1'b0);
		build_msg(1, 3);
		exchange(1, 1'b0);
		end_test("chained blocks", e0);

		e0 = errors;
		repeat (3)
			run_both(1'b0);
		end_test("both ports at once", e0);

		e0 = errors;
		repeat (4)
			run_both(1'b1);
		end_test("input gaps and output stalls", e0);

		e0 = errors;
		build_msg(1, 1);
		exchange(1, 1'b0);
		end_test("latency on idle port 1", e0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Budget of 200 cycles per block and 100 per message
	initial
	begin
		repeat (watchdog_cycles)
			@(posedge clk);
		$display("timeout after %0d cycles, a message or digest never completed",
			watchdog_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

//--- tb.f
verilog/sha1_pkg.sv
verilog/sha1_exec.sv
verilog/sha1_port.sv
verilog/sha1_core_arbiter.sv
verilog/sha1_hub.sv
testbench/sha1_hub_sva.sv
testbench/sha1_hub_tb.sv
